//--- soc_map_pkg.sv
package soc_map_pkg;

    // ======================================================================
    // Address map of the board bus
    // ======================================================================

    // Byte address on the CPU bus
    typedef logic [31:0] addr_t;

    // Access target after decode
    typedef enum logic [2:0] {
        REG_NONE,
        REG_RAM,
        REG_KEY,
        REG_UART,
        REG_SD_ADDR,
        REG_SD_READ,
        REG_SD_AVAIL,
        REG_SD_BUF
    } region_t;

    // Block RAM, 32-bit words
    localparam addr_t RAM_BASE  = 32'h0000_1000;
    localparam int    RAM_WORDS = 1024;
    localparam addr_t RAM_BYTES = addr_t'(RAM_WORDS * 4);
    localparam int    RAM_AW    = $clog2(RAM_WORDS);

    // Word index into the RAM array
    typedef logic [RAM_AW-1:0] ram_index_t;

    // Single-word registers
    localparam addr_t KEY_ADDR     = 32'h0000_3000;
    localparam addr_t UART_ADDR    = 32'h0000_3008;
    localparam addr_t SD_ADDR_REG  = 32'h0000_3010;
    localparam addr_t SD_READ_REG  = 32'h0000_3018;
    localparam addr_t SD_AVAIL_REG = 32'h0000_3020;

    // SD sector buffer, byte wide
    localparam addr_t SD_BUF_BASE     = 32'h0000_4000;
    localparam int    SD_SECTOR_BYTES = 512;

endpackage

//--- bus_pkg.sv
package bus_pkg;

    // ======================================================================
    // Bus data types and pipeline payloads
    // ======================================================================

    // CPU data word
    typedef logic [63:0] data_t;

    // Key code, UART and SD bytes
    typedef logic [7:0] byte_t;

    // Byte index into the SD sector buffer
    typedef logic [8:0] sd_index_t;

    // Request from the CPU
    typedef struct packed {
        logic               write;
        soc_map_pkg::addr_t addr;
        data_t              wdata;
    } bus_req_t;

    // Decode to execute
    typedef struct packed {
        bus_req_t             req;
        soc_map_pkg::region_t region;
    } dec_req_t;

    // Execute to result
    typedef struct packed {
        logic                 write;
        soc_map_pkg::region_t region;
        data_t                rdata;
    } exe_res_t;

    // Read response to the CPU
    typedef struct packed {
        data_t rdata;
        logic  err;
    } bus_resp_t;

    // Credits held by the CPU out of reset
    localparam int BUS_CREDITS = 4;

endpackage

//--- bus_decode.sv
`timescale 1ns/10ps

module bus_decode (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              req_valid,
    input  bus_pkg::bus_req_t req,
    output logic              dec_valid,
    output bus_pkg::dec_req_t dec
);

    soc_map_pkg::region_t region;
    soc_map_pkg::addr_t   a;

    // Address classification against the fixed map
    always_comb begin
        a = req.addr;
        region = soc_map_pkg::REG_NONE;
        if (a >= soc_map_pkg::RAM_BASE &&
            a < soc_map_pkg::RAM_BASE + soc_map_pkg::RAM_BYTES) begin
            // Only whole words in RAM
            if (a[1:0] == 2'b00) begin
                region = soc_map_pkg::REG_RAM;
            end
        end else if (a >= soc_map_pkg::SD_BUF_BASE &&
                     a < soc_map_pkg::SD_BUF_BASE +
                         soc_map_pkg::addr_t'(soc_map_pkg::SD_SECTOR_BYTES)) begin
            region = soc_map_pkg::REG_SD_BUF;
        end else begin
            case (a)
                soc_map_pkg::KEY_ADDR:     region = soc_map_pkg::REG_KEY;
                soc_map_pkg::UART_ADDR:    region = soc_map_pkg::REG_UART;
                soc_map_pkg::SD_ADDR_REG:  region = soc_map_pkg::REG_SD_ADDR;
                soc_map_pkg::SD_READ_REG:  region = soc_map_pkg::REG_SD_READ;
                soc_map_pkg::SD_AVAIL_REG: region = soc_map_pkg::REG_SD_AVAIL;
                default:                   region = soc_map_pkg::REG_NONE;
            endcase
        end
    end

    // Stage valid
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req_valid;
        end
    end

    // Request payload, only loaded on acceptance
    always_ff @(posedge CLOCK_50) begin
        if (req_valid) begin
            dec.req    <= req;
            dec.region <= region;
        end
    end

endmodule

//--- bus_execute.sv
`timescale 1ns/10ps

module bus_execute (
    input  logic                  CLOCK_50,
    input  logic                  KEY0,
    input  logic                  dec_valid,
    input  bus_pkg::dec_req_t     dec,
    output logic                  exe_valid,
    output bus_pkg::exe_res_t     exe,
    input  bus_pkg::byte_t        key_code,
    input  logic                  sd_avail,
    output bus_pkg::sd_index_t    sd_rd_index,
    input  bus_pkg::byte_t        sd_rd_byte,
    output logic                  uart_valid,
    output bus_pkg::byte_t        uart_byte,
    output logic                  sd_rd_start,
    output soc_map_pkg::addr_t    sd_addr
);

    // Block RAM, 1024 x 32
    logic [31:0] ram [0:soc_map_pkg::RAM_WORDS-1];
    logic [31:0] ram_q;

    soc_map_pkg::addr_t     ram_off;
    soc_map_pkg::addr_t     sd_off;
    soc_map_pkg::ram_index_t ram_idx;

    logic                 wr_hit;
    logic                 exe_write;
    soc_map_pkg::region_t exe_region;
    bus_pkg::data_t       reg_val;
    bus_pkg::data_t       reg_next;

    // ======================================================================
    // Address offsets
    // ======================================================================
    always_comb begin
        ram_off = dec.req.addr - soc_map_pkg::RAM_BASE;
        sd_off  = dec.req.addr - soc_map_pkg::SD_BUF_BASE;
        ram_idx = ram_off[soc_map_pkg::RAM_AW+1:2];
    end

    // Sector buffer read index, sampled by the fill block this cycle
    assign sd_rd_index = sd_off[8:0];

    assign wr_hit = dec_valid && dec.req.write;

    // RAM port, synchronous read
    always_ff @(posedge CLOCK_50) begin
        if (wr_hit && dec.region == soc_map_pkg::REG_RAM) begin
            ram[ram_idx] <= dec.req.wdata[31:0];
        end
        ram_q <= ram[ram_idx];
    end

    // Register read values
    always_comb begin
        case (dec.region)
            soc_map_pkg::REG_KEY:      reg_next = {56'b0, key_code};
            soc_map_pkg::REG_SD_ADDR:  reg_next = {32'b0, sd_addr};
            soc_map_pkg::REG_SD_AVAIL: reg_next = {63'b0, sd_avail};
            // UART and SD_READ are write only
            default:                   reg_next = '0;
        endcase
    end

    // ======================================================================
    // Stage registers
    // ======================================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        exe_write  <= dec.req.write;
        exe_region <= dec.region;
        reg_val    <= reg_next;
    end

    // Local read value, RAM and sector byte land this cycle
    always_comb begin
        exe.write  = exe_write;
        exe.region = exe_region;
        case (exe_region)
            soc_map_pkg::REG_RAM:    exe.rdata = {32'b0, ram_q};
            soc_map_pkg::REG_SD_BUF: exe.rdata = {56'b0, sd_rd_byte};
            default:                 exe.rdata = reg_val;
        endcase
    end

    // ======================================================================
    // Side effects
    // ======================================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_valid  <= 1'b0;
            sd_rd_start <= 1'b0;
            sd_addr     <= '0;
        end else begin
            // One-cycle strobes, each request is one cycle
            uart_valid  <= wr_hit && dec.region == soc_map_pkg::REG_UART;
            sd_rd_start <= wr_hit && dec.region == soc_map_pkg::REG_SD_READ;
            if (wr_hit && dec.region == soc_map_pkg::REG_SD_ADDR) begin
                sd_addr <= dec.req.wdata[31:0];
            end
        end
    end

    // UART byte, low byte of the write data
    always_ff @(posedge CLOCK_50) begin
        if (wr_hit && dec.region == soc_map_pkg::REG_UART) begin
            uart_byte <= dec.req.wdata[7:0];
        end
    end

endmodule

//--- bus_result.sv
`timescale 1ns/10ps

module bus_result (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  logic               exe_valid,
    input  bus_pkg::exe_res_t  exe,
    input  bus_pkg::byte_t     sd_rd_byte,
    output logic               resp_valid,
    output bus_pkg::bus_resp_t resp,
    output logic               credit_return
);

    bus_pkg::data_t rd_val;
    logic           rd_err;

    // Read value and error flag
    always_comb begin
        rd_val = exe.rdata;
        rd_err = 1'b0;
        case (exe.region)
            // Sector byte straight from the synchronous read port
            soc_map_pkg::REG_SD_BUF: rd_val = {56'b0, sd_rd_byte};
            // Unmapped, zero data with error
            soc_map_pkg::REG_NONE: begin
                rd_val = '0;
                rd_err = !exe.write;
            end
            default: rd_val = exe.rdata;
        endcase
    end

    // ======================================================================
    // Retire, response for reads, credit for every request
    // ======================================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            resp_valid    <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            resp_valid    <= exe_valid && !exe.write;
            credit_return <= exe_valid;
        end
    end

    // Response payload
    always_ff @(posedge CLOCK_50) begin
        if (exe_valid && !exe.write) begin
            resp.rdata <= rd_val;
            resp.err   <= rd_err;
        end
    end

endmodule

//--- sd_sector_fill.sv
`timescale 1ns/10ps

module sd_sector_fill (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  logic               sd_rd_start,
    input  logic               sd_byte_valid,
    input  bus_pkg::byte_t     sd_byte,
    input  bus_pkg::sd_index_t sd_rd_index,
    output bus_pkg::byte_t     sd_rd_byte,
    output logic               sd_avail
);

    // Sector buffer
    bus_pkg::byte_t sector_mem [0:soc_map_pkg::SD_SECTOR_BYTES-1];

    bus_pkg::sd_index_t wr_idx;
    logic               last_byte;

    assign last_byte = wr_idx == bus_pkg::sd_index_t'(soc_map_pkg::SD_SECTOR_BYTES - 1);

    // Fill index and sticky sector flag
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_idx   <= '0;
            sd_avail <= 1'b0;
        end else if (sd_rd_start) begin
            // New command restarts the sector
            wr_idx   <= '0;
            sd_avail <= 1'b0;
        end else if (sd_byte_valid) begin
            // Index wraps to 0 after byte 511
            wr_idx <= wr_idx + 1'b1;
            if (last_byte) begin
                sd_avail <= 1'b1;
            end
        end
    end

    // Byte write and one-cycle read port
    always_ff @(posedge CLOCK_50) begin
        if (sd_byte_valid && !sd_rd_start) begin
            sector_mem[wr_idx] <= sd_byte;
        end
        sd_rd_byte <= sector_mem[sd_rd_index];
    end

endmodule

//--- key_irq.sv
`timescale 1ns/10ps

module key_irq (
    input  logic           CLOCK_50,
    input  logic           KEY0,
    input  logic           key_pressed,
    input  bus_pkg::byte_t key_ascii,
    input  logic           irq_ack,
    output bus_pkg::byte_t key_code,
    output logic           irq,
    output logic [3:0]     irq_vector
);

    logic key_d;
    logic press_seen;

    // Rising edge with a usable code
    logic press;
    assign press = key_pressed && !key_d && key_ascii != 8'h00;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_d      <= 1'b0;
            press_seen <= 1'b0;
            key_code   <= '0;
            irq        <= 1'b0;
            irq_vector <= 4'd0;
        end else begin
            key_d      <= key_pressed;
            press_seen <= press;
            if (press) begin
                key_code <= key_ascii;
            end
            // Pending until ack, a press in the same cycle wins
            if (press_seen) begin
                irq        <= 1'b1;
                irq_vector <= 4'd1;
            end else if (irq_ack) begin
                irq        <= 1'b0;
                irq_vector <= 4'd0;
            end
        end
    end

endmodule

//--- soc_bus_top.sv
`timescale 1ns/10ps

module soc_bus_top (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  logic               req_valid,
    input  bus_pkg::bus_req_t  req,
    output logic               credit_return,
    output logic               resp_valid,
    output bus_pkg::bus_resp_t resp,
    input  logic               key_pressed,
    input  bus_pkg::byte_t     key_ascii,
    output logic               irq,
    output logic [3:0]         irq_vector,
    input  logic               irq_ack,
    output logic               uart_valid,
    output bus_pkg::byte_t     uart_byte,
    output logic               sd_rd_start,
    output soc_map_pkg::addr_t sd_addr,
    input  logic               sd_byte_valid,
    input  bus_pkg::byte_t     sd_byte
);

    // Decode to execute
    logic              dec_valid;
    bus_pkg::dec_req_t dec;

    // Execute to result
    logic              exe_valid;
    bus_pkg::exe_res_t exe;

    // Keyboard and sector buffer side
    bus_pkg::byte_t     key_code;
    logic               sd_avail;
    bus_pkg::sd_index_t sd_rd_index;
    bus_pkg::byte_t     sd_rd_byte;

    // ======================================================================
    // Three-stage bus pipeline
    // ======================================================================
    bus_decode u_decode (.*);

    bus_execute u_execute (.*);

    bus_result u_result (.*);

    // Peripherals
    sd_sector_fill u_sd_fill (.*);

    key_irq u_key_irq (.*);

endmodule

//--- soc_bus_sva.sv
`timescale 1ns/10ps

module soc_bus_sva (
    input logic              CLOCK_50,
    input logic              KEY0,
    input logic              req_valid,
    input bus_pkg::bus_req_t req,
    input logic              credit_return,
    input logic              resp_valid,
    input logic              uart_valid,
    input logic              sd_rd_start,
    input logic              irq
);

    // Requests in flight
    int outstanding;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(req_valid) - int'(credit_return);
        end
    end

    // ======================================================================
    // Properties
    // ======================================================================
    a_credit: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        credit_return |-> outstanding > 0) else $error("credit returned with none outstanding");

    a_resp: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        req_valid && !req.write |-> ##3 resp_valid) else $error("read response late");

    a_uart: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_valid |=> !uart_valid) else $error("uart_valid longer than one cycle");

    a_sd: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start |=> !sd_rd_start) else $error("sd_rd_start longer than one cycle");

    a_irq: assert property (@(posedge CLOCK_50)
        $rose(KEY0) |-> !irq) else $error("irq high out of reset");

endmodule

bind soc_bus_top soc_bus_sva sva0 (.*);

//--- tb_soc_bus.sv
`timescale 1ns/10ps

module tb_soc_bus;

    logic                 CLOCK_50;
    logic                 KEY0;
    logic                 req_valid;
    bus_pkg::bus_req_t    req;
    logic                 credit_return;
    logic                 resp_valid;
    bus_pkg::bus_resp_t   resp;
    logic                 key_pressed;
    bus_pkg::byte_t       key_ascii;
    logic                 irq;
    logic [3:0]           irq_vector;
    logic                 irq_ack;
    logic                 uart_valid;
    bus_pkg::byte_t       uart_byte;
    logic                 sd_rd_start;
    soc_map_pkg::addr_t   sd_addr;
    logic                 sd_byte_valid;
    bus_pkg::byte_t       sd_byte;

    // Driver state and scoreboard
    int                   credits;
    int                   value_errors;
    int                   other_errors;
    integer               seed;
    bus_pkg::bus_resp_t   exp_q[$];
    bus_pkg::byte_t       uart_q[$];
    logic                 capture;
    bus_pkg::bus_resp_t   last_resp;
    int                   sd_start_count;
    soc_map_pkg::addr_t   last_sd_addr;
    logic [31:0]          ram_model [int];
    bus_pkg::byte_t       sd_model [0:511];

    soc_bus_top dut0 (.*);

    always #4 CLOCK_50 = ~CLOCK_50;

    // ======================================================================
    // Monitors, sampled on the rising edge
    // ======================================================================
    always @(posedge CLOCK_50) begin
        if (KEY0) begin
            if (credit_return) credits = credits + 1;
            if (uart_valid) uart_q.push_back(uart_byte);
            if (sd_rd_start) begin
                sd_start_count = sd_start_count + 1;
                last_sd_addr = sd_addr;
            end
            if (resp_valid) begin
                if (capture) begin
                    last_resp = resp;
                    capture = 1'b0;
                end else if (exp_q.size() == 0) begin
                    $display("Response arrived with no read outstanding at %0t", $time);
                    other_errors++;
                end else begin
                    check_resp(resp, exp_q.pop_front(), "resp");
                end
            end
        end
    end

    // ======================================================================
    // Compare tasks
    // ======================================================================
    task automatic check_data(input bus_pkg::data_t act, input bus_pkg::data_t exp,
                              input string name);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_resp(input bus_pkg::bus_resp_t act, input bus_pkg::bus_resp_t exp,
                              input string name);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h/%b, got %h/%b", $time, name,
                     exp.rdata, exp.err, act.rdata, act.err);
            value_errors++;
        end
    endtask

    task automatic check_byte(input bus_pkg::byte_t act, input bus_pkg::byte_t exp,
                              input string name);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    // ======================================================================
    // Driver
    // ======================================================================
    // Puts one request on the bus, waiting for a credit first
    task automatic issue(input logic wr, input soc_map_pkg::addr_t addr,
                         input bus_pkg::data_t wdata, input bus_pkg::bus_resp_t exp);
        int n;
        n = 0;
        @(negedge CLOCK_50);
        while (credits == 0 && n < 50) begin
            req_valid = 1'b0;
            @(negedge CLOCK_50);
            n++;
        end
        if (credits == 0) begin
            $display("Timed out waiting for a bus credit at %0t", $time);
            other_errors++;
        end
        req_valid = 1'b1;
        req.write = wr;
        req.addr = addr;
        req.wdata = wdata;
        credits = credits - 1;
        if (!wr) exp_q.push_back(exp);
    endtask

    task automatic idle();
        @(negedge CLOCK_50);
        req_valid = 1'b0;
    endtask

    // Waits until every credit is back and every read answered
    task automatic drain();
        int n;
        n = 0;
        while ((credits != bus_pkg::BUS_CREDITS || exp_q.size() != 0 || capture) && n < 100) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (n >= 100) begin
            $display("Timed out waiting for the pipeline to drain at %0t", $time);
            other_errors++;
        end
    endtask

    // Single read whose response is handed back to the caller
    task automatic read_direct(input soc_map_pkg::addr_t addr, output bus_pkg::bus_resp_t r);
        @(negedge CLOCK_50);
        capture = 1'b1;
        req_valid = 1'b1;
        req.write = 1'b0;
        req.addr = addr;
        credits = credits - 1;
        idle();
        drain();
        r = last_resp;
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic test_ram();
        int idx [8];
        logic [31:0] w;
        for (int i = 0; i < 8; i++) begin
            idx[i] = $random(seed) & 1023;
            w = $random(seed);
            ram_model[idx[i]] = w;
            issue(1'b1, soc_map_pkg::RAM_BASE + idx[i] * 4, {$random(seed), w}, '0);
        end
        for (int i = 0; i < 8; i++) begin
            issue(1'b0, soc_map_pkg::RAM_BASE + idx[i] * 4, '0,
                  {32'b0, ram_model[idx[i]], 1'b0});
        end
        idle();
        drain();
    endtask

    task automatic test_credits();
        logic [31:0] w;
        // Known contents for the four words read back to back
        for (int i = 0; i < 4; i++) begin
            w = $random(seed);
            ram_model[i + 16] = w;
            issue(1'b1, soc_map_pkg::RAM_BASE + (i + 16) * 4, {32'b0, w}, '0);
        end
        idle();
        drain();
        for (int i = 0; i < 4; i++) begin
            issue(1'b0, soc_map_pkg::RAM_BASE + (i + 16) * 4, '0,
                  {32'b0, ram_model[i + 16], 1'b0});
        end
        if (credits != 0) begin
            $display("Driver should hold no credit after four reads, holds %0d", credits);
            other_errors++;
        end
        idle();
        drain();
    endtask

    task automatic test_unmapped();
        bus_pkg::bus_resp_t r;
        issue(1'b0, 32'h0000_8000, '0, {64'b0, 1'b1});
        // Same low address bits as the first RAM word written
        issue(1'b1, 32'h0000_8000 + idx_of_first() * 4, 64'hdead_beef, '0);
        idle();
        drain();
        read_direct(soc_map_pkg::RAM_BASE + idx_of_first() * 4, r);
        check_data(r.rdata, {32'b0, ram_model[idx_of_first()]}, "ram_word");
    endtask

    function automatic int idx_of_first();
        int k;
        void'(ram_model.first(k));
        return k;
    endfunction

    task automatic test_uart();
        bus_pkg::byte_t sent [4];
        for (int i = 0; i < 4; i++) begin
            sent[i] = $random(seed);
            issue(1'b1, soc_map_pkg::UART_ADDR, {56'h0123_4567_89ab_cd, sent[i]}, '0);
            // One idle cycle between writes
            idle();
        end
        drain();
        if (uart_q.size() != 4) begin
            $display("Expected 4 UART strobes, saw %0d", uart_q.size());
            other_errors++;
        end
        for (int i = 0; i < 4 && uart_q.size() > 0; i++) begin
            check_byte(uart_q.pop_front(), sent[i], "uart_byte");
        end
    endtask

    task automatic test_sd();
        bus_pkg::bus_resp_t r;
        int n;
        int offs [6] = '{0, 1, 100, 255, 300, 511};
        issue(1'b1, soc_map_pkg::SD_ADDR_REG, 64'h0000_0000_0000_0a5c, '0);
        issue(1'b1, soc_map_pkg::SD_READ_REG, '0, '0);
        idle();
        drain();
        if (sd_start_count != 1) begin
            $display("Expected one sd_rd_start pulse, saw %0d", sd_start_count);
            other_errors++;
        end
        check_data({32'b0, last_sd_addr}, 64'h0a5c, "sd_addr");
        for (int i = 0; i < 512; i++) begin
            @(negedge CLOCK_50);
            sd_model[i] = $random(seed);
            sd_byte = sd_model[i];
            sd_byte_valid = 1'b1;
        end
        @(negedge CLOCK_50);
        sd_byte_valid = 1'b0;
        n = 0;
        r = '0;
        while (r.rdata != 64'd1 && n < 20) begin
            read_direct(soc_map_pkg::SD_AVAIL_REG, r);
            n++;
        end
        if (r.rdata != 64'd1) begin
            $display("Timed out polling the sector available flag");
            other_errors++;
        end
        for (int i = 0; i < 6; i++) begin
            issue(1'b0, soc_map_pkg::SD_BUF_BASE + offs[i], '0,
                  {56'b0, sd_model[offs[i]], 1'b0});
        end
        idle();
        drain();
    endtask

    task automatic test_key();
        bus_pkg::bus_resp_t r;
        int n;
        @(negedge CLOCK_50);
        key_ascii = 8'h4b;
        key_pressed = 1'b1;
        n = 0;
        while (!irq && n < 20) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (!irq) begin
            $display("Timed out waiting for the keyboard interrupt");
            other_errors++;
        end
        check_byte({4'b0, irq_vector}, 8'd1, "irq_vector");
        key_pressed = 1'b0;
        read_direct(soc_map_pkg::KEY_ADDR, r);
        check_data(r.rdata, 64'h4b, "key_code");
        @(negedge CLOCK_50);
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
        n = 0;
        while (irq && n < 20) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (irq) begin
            $display("Interrupt still pending after acknowledge");
            other_errors++;
        end
    endtask

    initial begin
        CLOCK_50 = 1'b0;
        KEY0 = 1'b0;
        req_valid = 1'b0;
        req = '0;
        key_pressed = 1'b0;
        key_ascii = '0;
        irq_ack = 1'b0;
        sd_byte_valid = 1'b0;
        sd_byte = '0;
        credits = bus_pkg::BUS_CREDITS;
        value_errors = 0;
        other_errors = 0;
        seed = 42549;
        capture = 1'b0;
        sd_start_count = 0;
        repeat (8) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        test_ram();
        test_credits();
        test_unmapped();
        test_uart();
        test_sd();
        test_key();
        repeat (4) @(negedge CLOCK_50);
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog.f
soc_map_pkg.sv
bus_pkg.sv
bus_decode.sv
bus_execute.sv
bus_result.sv
sd_sector_fill.sv
key_irq.sv
soc_bus_top.sv
soc_bus_sva.sv
tb_soc_bus.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bus testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_bus \
    -f verilog.f -o sim_tb > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || true

grep -F -q "*** PASSED ***" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
